//--- mem_config.svh
/* memory sizes: address and data widths, line count,
   tag count, minimum latency and counter width */

`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// bus widths
`define XLEN         32
`define DATA_W       64

// 64-bit words held by the array
`define MEM_LINES    64

// tags 1..15 usable, 0 means none
`define NUM_MEM_TAGS 15

// cycles from acceptance until the tag is ready
`define MEM_LATENCY  4
`define LAT_W        4 // must hold MEM_LATENCY

`endif

//--- mem_pkg.sv
/* memory types, bus command codes and the lowest-tag
   priority function shared by grant and return */

`default_nettype none
`include "mem_config.svh"

package mem_pkg;

	typedef logic [`XLEN-1:0]                     addr_t;     // request address
	typedef logic [`DATA_W-1:0]                   data_t;     // bus data word
	typedef logic [$clog2(`NUM_MEM_TAGS+1)-1:0]   tag_t;      // 0 = none
	typedef logic [`LAT_W-1:0]                    lat_t;      // latency countdown
	typedef logic [$clog2(`MEM_LINES)-1:0]        line_idx_t; // array index
	typedef logic [1:0]                           bus_cmd_t;

	localparam bus_cmd_t BUS_NONE  = 2'h0;
	localparam bus_cmd_t BUS_LOAD  = 2'h1;
	localparam bus_cmd_t BUS_STORE = 2'h2;

	// tag number of the lowest set bit, bit k stands for tag k+1
	// returns 0 when the vector is empty
	function automatic tag_t first_tag(input logic [`NUM_MEM_TAGS-1:0] vec);
		tag_t t;
		t = '0;
		for (int k = `NUM_MEM_TAGS - 1; k >= 0; k--) begin // downward, lowest wins
			if (vec[k]) begin
				t = tag_t'(k + 1);
			end
		end
		return t;
	endfunction

endpackage

`default_nettype wire

//--- mem_line_store.sv
/* memory array: MEM_LINES data words, combinational read,
   posedge write, whole array cleared on reset */

`timescale 1ns/1ps
`default_nettype none
`include "mem_config.svh"

module mem_line_store import mem_pkg::*; (
	input  wire logic      clk,
	input  wire logic      arst_n,

	// write port, driven on store acceptance
	input  wire logic      wr_en,
	input  wire line_idx_t wr_idx,
	input  wire data_t     wr_data,

	// read port, same cycle
	input  wire line_idx_t rd_idx,
	output data_t          rd_data
);

	//////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////

	data_t lines [`MEM_LINES]; // one 64-bit word per line

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `MEM_LINES; i++) begin
				lines[i] <= '0; // array starts all zero
			end
		end else if (wr_en) begin
			lines[wr_idx] <= wr_data;
		end
	end

	//////////////////////////////////////////////////
	// read
	//////////////////////////////////////////////////

	// no read register, so the tag table samples the word
	// at the very edge that accepts the load
	assign rd_data = lines[rd_idx];

	// a store and a load in back-to-back cycles to the same line:
	// the store lands at its acceptance edge, so the load
	// one cycle later already reads the new word

endmodule

`default_nettype wire

//--- mem_tag_table.sv
/* tag table: request check, lowest idle tag grant, per-tag latency
   counters, waiting flags, captured load data and the response register */

`timescale 1ns/1ps
`default_nettype none
`include "mem_config.svh"

module mem_tag_table import mem_pkg::*; (
	input  wire logic                          clk,
	input  wire logic                          arst_n,

	// request bus
	input  wire addr_t                         proc2mem_addr,
	input  wire data_t                         proc2mem_data,
	input  wire bus_cmd_t                      proc2mem_command,

	// return side, bit k stands for tag k+1
	input  wire logic [`NUM_MEM_TAGS-1:0]      pick,
	output logic [`NUM_MEM_TAGS-1:0]           ready,
	output logic [`NUM_MEM_TAGS*`DATA_W-1:0]   slot_data,

	// array side
	output logic                               wr_en,
	output line_idx_t                          wr_idx,
	output data_t                              wr_data,
	output line_idx_t                          rd_idx,
	input  wire data_t                         rd_data,

	// response bus
	output tag_t                               mem2proc_response
);

	//////////////////////////////////////////////////
	// per-tag state
	//////////////////////////////////////////////////

	lat_t                       cnt [`NUM_MEM_TAGS]; // cycles left until ready
	logic [`NUM_MEM_TAGS-1:0]   waiting;             // accepted, not yet returned
	data_t                      slot_q [`NUM_MEM_TAGS]; // load data or 0 for store

	logic [`NUM_MEM_TAGS-1:0]   idle;      // free to grant
	logic [`NUM_MEM_TAGS-1:0]   grant_vec; // one-hot, tag taken this edge

	//////////////////////////////////////////////////
	// request check
	//////////////////////////////////////////////////

	logic  is_load;
	logic  is_store;
	logic  addr_ok;
	logic  req_valid;
	logic  accept;
	tag_t  grant_tag;

	assign is_load   = (proc2mem_command == BUS_LOAD);
	assign is_store  = (proc2mem_command == BUS_STORE);
	assign addr_ok   = (proc2mem_addr < addr_t'(`MEM_LINES)); // out of range is refused
	assign req_valid = (is_load || is_store) && addr_ok;

	// slot status, both decoded from counter and flag
	always_comb begin
		for (int k = 0; k < `NUM_MEM_TAGS; k++) begin
			idle[k]  = (cnt[k] == '0) && !waiting[k];
			ready[k] = (cnt[k] == '0) && waiting[k]; // done counting, wants the bus
		end
	end

	assign grant_tag = first_tag(idle);             // 0 when every tag busy
	assign accept    = req_valid && (grant_tag != '0);

	always_comb begin
		for (int k = 0; k < `NUM_MEM_TAGS; k++) begin
			grant_vec[k] = accept && (grant_tag == tag_t'(k + 1));
		end
	end

	//////////////////////////////////////////////////
	// array access
	//////////////////////////////////////////////////

	assign rd_idx  = line_idx_t'(proc2mem_addr); // low bits, range checked above
	assign wr_idx  = line_idx_t'(proc2mem_addr);
	assign wr_data = proc2mem_data;
	assign wr_en   = accept && is_store;         // write lands at acceptance edge

	//////////////////////////////////////////////////
	// counters, flags, response
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int k = 0; k < `NUM_MEM_TAGS; k++) begin
				cnt[k] <= '0;
			end
			waiting           <= '0;
			mem2proc_response <= '0;
		end else begin
			for (int k = 0; k < `NUM_MEM_TAGS; k++) begin
				if (cnt[k] != '0) begin
					cnt[k] <= cnt[k] - lat_t'(1); // count down once per edge
				end else if (grant_vec[k]) begin
					cnt[k] <= lat_t'(`MEM_LATENCY);
				end

				// grant needs an idle slot and pick a ready one,
				// so both never hit the same tag
				if (grant_vec[k]) begin
					waiting[k] <= 1'b1; // stores wait too, they return an ack
				end else if (pick[k]) begin
					waiting[k] <= 1'b0; // idle from the next edge
				end
			end
			mem2proc_response <= accept ? grant_tag : '0; // one-cycle strobe
		end
	end

	// captured data, only read while the slot is waiting
	always_ff @(posedge clk) begin
		for (int k = 0; k < `NUM_MEM_TAGS; k++) begin
			if (grant_vec[k]) begin
				slot_q[k] <= is_load ? rd_data : '0;
			end
		end
	end

	// flatten for the return select, slot k at bits k*DATA_W up
	always_comb begin
		for (int k = 0; k < `NUM_MEM_TAGS; k++) begin
			slot_data[k*`DATA_W +: `DATA_W] = slot_q[k];
		end
	end

endmodule

`default_nettype wire

//--- mem_return_select.sv
/* return select: fixed priority pick of the lowest ready tag
   and the registered return bus */

`timescale 1ns/1ps
`default_nettype none
`include "mem_config.svh"

module mem_return_select import mem_pkg::*; (
	input  wire logic                          clk,
	input  wire logic                          arst_n,

	// from the tag table, bit k stands for tag k+1
	input  wire logic [`NUM_MEM_TAGS-1:0]      ready,
	input  wire logic [`NUM_MEM_TAGS*`DATA_W-1:0] slot_data,
	output logic [`NUM_MEM_TAGS-1:0]           pick, // clears the waiting flag

	// return bus
	output tag_t                               mem2proc_tag,
	output data_t                              mem2proc_data
);

	//////////////////////////////////////////////////
	// priority pick
	//////////////////////////////////////////////////

	tag_t  pick_tag;  // 0 when nothing ready
	data_t pick_data;

	assign pick_tag = first_tag(ready); // lowest tag first

	// decode back to one-hot and select that slot's word
	always_comb begin
		pick      = '0;
		pick_data = '0; // nothing ready, data 0 on the bus
		for (int k = 0; k < `NUM_MEM_TAGS; k++) begin
			if (pick_tag == tag_t'(k + 1)) begin
				pick[k]   = 1'b1;
				pick_data = slot_data[k*`DATA_W +: `DATA_W];
			end
		end
	end

	//////////////////////////////////////////////////
	// return bus registers
	//////////////////////////////////////////////////

	// others stay in ready and try again next edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem2proc_tag  <= '0;
			mem2proc_data <= '0;
		end else begin
			mem2proc_tag  <= pick_tag;  // nonzero for exactly one cycle
			mem2proc_data <= pick_data; // store ack carries 0
		end
	end

	// the tag leaves ready at the same edge it is registered here,
	// so one completion per cycle and no double return

endmodule

`default_nettype wire

//--- mem.sv
/* top level: tagged pipelined memory with request, response
   and return buses, built from tag table, array and return select */

`timescale 1ns/1ps
`default_nettype none
`include "mem_config.svh"

module mem import mem_pkg::*; (
	input  wire logic     clk,
	input  wire logic     arst_n,

	// request bus
	input  wire addr_t    proc2mem_addr,
	input  wire data_t    proc2mem_data,
	input  wire bus_cmd_t proc2mem_command,   // BUS_NONE, BUS_LOAD or BUS_STORE

	// response and return buses
	output tag_t          mem2proc_response,  // 0 = refused, else granted tag
	output data_t         mem2proc_data,      // load data, 0 for store ack
	output tag_t          mem2proc_tag        // 0 = nothing returned
);

	//////////////////////////////////////////////////
	// internal wiring
	//////////////////////////////////////////////////

	logic                               wr_en;
	line_idx_t                          wr_idx;
	data_t                              wr_data;
	line_idx_t                          rd_idx;
	data_t                              rd_data;   // combinational array read

	logic [`NUM_MEM_TAGS-1:0]           ready;     // bit k = tag k+1
	logic [`NUM_MEM_TAGS-1:0]           pick;
	logic [`NUM_MEM_TAGS*`DATA_W-1:0]   slot_data;

	mem_tag_table tag_table_i (
		.clk               (clk),
		.arst_n            (arst_n),
		.proc2mem_addr     (proc2mem_addr),
		.proc2mem_data     (proc2mem_data),
		.proc2mem_command  (proc2mem_command),
		.pick              (pick),
		.ready             (ready),
		.slot_data         (slot_data),
		.wr_en             (wr_en),
		.wr_idx            (wr_idx),
		.wr_data           (wr_data),
		.rd_idx            (rd_idx),
		.rd_data           (rd_data),
		.mem2proc_response (mem2proc_response)
	);

	mem_line_store line_store_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.wr_en   (wr_en),
		.wr_idx  (wr_idx),
		.wr_data (wr_data),
		.rd_idx  (rd_idx),
		.rd_data (rd_data)
	);

	mem_return_select return_select_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.ready         (ready),
		.slot_data     (slot_data),
		.pick          (pick),
		.mem2proc_tag  (mem2proc_tag),
		.mem2proc_data (mem2proc_data)
	);

endmodule

`default_nettype wire

//--- mem_asserts.sv
/* concurrent checks bound into mem: grant of free tags only,
   lowest ready pick, outputs after reset and minimum return latency */

`timescale 1ns/1ps
`default_nettype none
`include "mem_config.svh"

module mem_asserts import mem_pkg::*; (
	input  wire logic                     clk,
	input  wire logic                     arst_n,
	input  wire tag_t                     mem2proc_response,
	input  wire tag_t                     mem2proc_tag,
	input  wire data_t                    mem2proc_data,
	input  wire logic [`NUM_MEM_TAGS-1:0] ready,
	input  wire logic [`NUM_MEM_TAGS-1:0] pick
);

	//////////////////////////////////////////////////
	// shadow of outstanding tags, seen from the buses
	//////////////////////////////////////////////////

	logic [`NUM_MEM_TAGS-1:0] busy_q;              // bit k = tag k+1
	logic [7:0]               age_q [`NUM_MEM_TAGS]; // cycles since response, saturates

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy_q <= '0;
			for (int k = 0; k < `NUM_MEM_TAGS; k++) begin
				age_q[k] <= '0;
			end
		end else begin
			for (int k = 0; k < `NUM_MEM_TAGS; k++) begin
				if (mem2proc_response == tag_t'(k + 1)) begin
					busy_q[k] <= 1'b1;
					age_q[k]  <= 8'd1; // strobe was up one cycle
				end else begin
					if (mem2proc_tag == tag_t'(k + 1)) begin
						busy_q[k] <= 1'b0;
					end
					if (age_q[k] != 8'hff) begin
						age_q[k] <= age_q[k] + 8'd1;
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// properties
	//////////////////////////////////////////////////

	a_grant_free: assert property (@(posedge clk) disable iff (!arst_n)
		mem2proc_response != '0 |-> !busy_q[mem2proc_response - tag_t'(1)])
		else $error("response names a tag that has not returned yet");

	// lowest set bit of ready, zero when nothing is ready
	a_pick_lowest: assert property (@(posedge clk) disable iff (!arst_n)
		pick == (ready & (~ready + 1'b1)))
		else $error("pick is not the lowest ready tag");

	a_reset_outputs: assert property (@(posedge clk)
		$rose(arst_n) |-> (mem2proc_response == '0 && mem2proc_tag == '0 &&
		mem2proc_data == '0))
		else $error("bus outputs not zero after reset");

	a_min_latency: assert property (@(posedge clk) disable iff (!arst_n)
		mem2proc_tag != '0 |-> age_q[mem2proc_tag - tag_t'(1)] >= 8'(`MEM_LATENCY + 1))
		else $error("tag returned earlier than the minimum latency");

endmodule

bind mem mem_asserts mem_asserts_i (
	.clk               (clk),
	.arst_n            (arst_n),
	.mem2proc_response (mem2proc_response),
	.mem2proc_tag      (mem2proc_tag),
	.mem2proc_data     (mem2proc_data),
	.ready             (ready),
	.pick              (pick)
);

`default_nettype wire

//--- tb_mem.sv
/* testbench for mem: directed and random requests, reference model
   of tags, latency and array, per-cycle bus checks and timeout */

`timescale 1ns/1ps
`default_nettype none
`include "mem_config.svh"

module tb_mem import mem_pkg::*; ();

	localparam int NUM_REQ   = 332; // 4 lone loads, 8 store/load, 20 burst, 300 random
	localparam int CYC_LIMIT = (NUM_REQ + 64) * (`MEM_LATENCY + 2);

	typedef struct packed {
		tag_t        tag;
		data_t       data;
		logic [15:0] extra; // edges spent ready but not picked
	} ret_t;

	logic     clk;
	logic     arst_n;
	addr_t    proc2mem_addr;
	data_t    proc2mem_data;
	bus_cmd_t proc2mem_command;
	tag_t     mem2proc_response;
	data_t    mem2proc_data;
	tag_t     mem2proc_tag;

	// reference model, tag number as index
	data_t       mirror [`MEM_LINES];
	logic        busy_m [1:`NUM_MEM_TAGS];
	lat_t        cnt_m  [1:`NUM_MEM_TAGS];
	data_t       slot_m [1:`NUM_MEM_TAGS];
	logic [15:0] wait_m [1:`NUM_MEM_TAGS];
	ret_t        exp_ret [$]; // expected returns
	tag_t        exp_resp;

	// what the DUT showed on its buses
	int     resp_cyc [1:`NUM_MEM_TAGS];
	int     grants_seen;
	int     returns_seen;
	int     cyc;
	int     tick = 0;
	integer seed;

	initial clk = 1'b0;
	always #4 clk = ~clk; // 8 ns

	mem mem_i (
		.clk               (clk),
		.arst_n            (arst_n),
		.proc2mem_addr     (proc2mem_addr),
		.proc2mem_data     (proc2mem_data),
		.proc2mem_command  (proc2mem_command),
		.mem2proc_response (mem2proc_response),
		.mem2proc_data     (mem2proc_data),
		.mem2proc_tag      (mem2proc_tag)
	);

	always @(posedge clk) begin
		tick = tick + 1;
		if (tick > CYC_LIMIT) begin
			$display("timeout: test still running after %0d cycles", tick);
			$display("=== FAIL ===");
			$fatal(1, "simulation timed out");
		end
	end

	task automatic check_val(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "value mismatch");
		end
	endtask

	//////////////////////////////////////////////////
	// model of one clock edge
	//////////////////////////////////////////////////

	task automatic model_edge(input bus_cmd_t cmd, input addr_t addr, input data_t data);
		tag_t r;
		tag_t g;
		logic ok;
		ret_t e;
		r  = '0;
		g  = '0;
		ok = (cmd == BUS_LOAD || cmd == BUS_STORE) && (addr < addr_t'(`MEM_LINES));
		for (int t = 1; t <= `NUM_MEM_TAGS; t++) begin // state before the edge
			if (r == '0 && busy_m[t] && cnt_m[t] == '0) r = tag_t'(t); // lowest ready
			if (g == '0 && !busy_m[t]) g = tag_t'(t);                   // lowest idle
		end
		for (int t = 1; t <= `NUM_MEM_TAGS; t++) begin
			if (busy_m[t] && cnt_m[t] != '0) cnt_m[t] = cnt_m[t] - lat_t'(1);
			else if (busy_m[t] && tag_t'(t) != r) wait_m[t] = wait_m[t] + 16'd1; // lost pick
		end
		if (r != '0) begin
			e.tag   = r;
			e.data  = slot_m[r];
			e.extra = wait_m[r];
			exp_ret.push_back(e);
			busy_m[r] = 1'b0; // idle from the next edge
		end
		exp_resp = '0;
		if (ok && g != '0) begin
			exp_resp  = g;
			busy_m[g] = 1'b1;
			cnt_m[g]  = lat_t'(`MEM_LATENCY);
			wait_m[g] = '0;
			slot_m[g] = (cmd == BUS_LOAD) ? mirror[line_idx_t'(addr)] : '0; // store acks 0
			if (cmd == BUS_STORE) mirror[line_idx_t'(addr)] = data;
		end
	endtask

	//////////////////////////////////////////////////
	// drive at negedge, check one cycle later
	//////////////////////////////////////////////////

	task automatic drive_cycle(input bus_cmd_t cmd, input addr_t addr, input data_t data);
		ret_t e;
		tag_t rt;
		proc2mem_command = cmd;
		proc2mem_addr    = addr;
		proc2mem_data    = data;
		model_edge(cmd, addr, data);
		@(negedge clk);
		cyc++;
		check_val("mem2proc_response", 64'(mem2proc_response), 64'(exp_resp));
		if (mem2proc_response != '0) begin
			resp_cyc[mem2proc_response] = cyc;
			grants_seen++;
		end
		if (exp_ret.size() == 0) begin
			check_val("mem2proc_tag", 64'(mem2proc_tag), 64'd0);
			check_val("mem2proc_data", mem2proc_data, 64'd0);
		end else begin
			e = exp_ret.pop_front();
			check_val("mem2proc_tag", 64'(mem2proc_tag), 64'(e.tag));
			check_val("mem2proc_data", mem2proc_data, e.data);
			rt = mem2proc_tag;
			// latency from strobe to return, plus time lost to lower tags
			check_val("return latency", 64'(cyc - resp_cyc[rt]),
				64'(`MEM_LATENCY + 1) + 64'(e.extra));
			returns_seen++;
		end
	endtask

	task automatic wait_returns();
		while (returns_seen != grants_seen) drive_cycle(BUS_NONE, '0, '0);
	endtask

	initial begin
		addr_t    a;
		bus_cmd_t c;
		data_t    d;
		int       r;
		seed             = 32'ha7a8e653;
		arst_n           = 1'b0;
		proc2mem_addr    = '0;
		proc2mem_data    = '0;
		proc2mem_command = BUS_NONE;
		cyc              = 0;
		grants_seen      = 0;
		returns_seen     = 0;
		exp_resp         = '0;
		for (int i = 0; i < `MEM_LINES; i++) mirror[i] = '0;
		for (int t = 1; t <= `NUM_MEM_TAGS; t++) begin
			busy_m[t]   = 1'b0;
			cnt_m[t]    = '0;
			slot_m[t]   = '0;
			wait_m[t]   = '0;
			resp_cyc[t] = 0;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		check_val("mem2proc_response", 64'(mem2proc_response), 64'd0);
		check_val("mem2proc_tag", 64'(mem2proc_tag), 64'd0);
		check_val("mem2proc_data", mem2proc_data, 64'd0);

		for (int i = 0; i < 4; i++) begin // lone loads, array still zero
			drive_cycle(BUS_LOAD, addr_t'(line_idx_t'($random(seed))), '0);
			wait_returns();
		end
		for (int i = 0; i < 4; i++) begin // load right behind a store, same line
			a = addr_t'(line_idx_t'($random(seed)));
			drive_cycle(BUS_STORE, a, {$random(seed), $random(seed)});
			drive_cycle(BUS_LOAD, a, '0);
		end
		wait_returns();
		// back-to-back loads, tags get reused as they come back
		for (int i = 0; i < 20; i++) drive_cycle(BUS_LOAD, addr_t'(i), '0);
		for (int i = 0; i < 300; i++) begin
			r = $random(seed);
			c = (r[1:0] == 2'd3) ? BUS_LOAD : bus_cmd_t'(r[1:0]);
			if ((r[15:8] % 8'd10) == 8'd0)
				a = addr_t'(`MEM_LINES) + addr_t'($random(seed) & 32'h0000_ffff);
			else
				a = addr_t'(line_idx_t'($random(seed)));
			d = {$random(seed), $random(seed)};
			drive_cycle(c, a, d);
		end
		wait_returns();
		repeat (`MEM_LATENCY + 2) drive_cycle(BUS_NONE, '0, '0); // nothing more may return

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
mem_pkg.sv
mem_line_store.sv
mem_tag_table.sv
mem_return_select.sv
mem.sv
mem_asserts.sv
tb_mem.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       := tb_mem
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) mem_config.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
